// ==== Bender.yml ====
package:
  name: rvDecodeCore

sources:
  - files:
      - verilog/rvPkg.sv
      - verilog/instDecoder.sv
      - verilog/regFile.sv
      - verilog/operandSelect.sv
      - verilog/execUnit.sv
      - verilog/decodeCore.sv
  - target: test
    files:
      - tb/decodeCoreTb.sv

// ==== rvDecodeCore.f ====
verilog/rvPkg.sv
verilog/instDecoder.sv
verilog/regFile.sv
verilog/operandSelect.sv
verilog/execUnit.sv
verilog/decodeCore.sv
tb/decodeCoreTb.sv

// ==== tb/decodeCoreTb.sv ====
module decodeCoreTb;
  timeunit 1ns;
  timeprecision 1ps;
  import rvPkg::*;

  localparam int MaxCycles = 400;
  localparam logic [6:0] OpReg = 7'b0110011;
  localparam logic [6:0] OpImm = 7'b0010011;
  localparam logic [6:0] OpRegW = 7'b0111011;
  localparam logic [6:0] OpImmW = 7'b0011011;

  logic        clk;
  logic        arstN;
  logic [63:0] pc;
  logic [31:0] inst;
  logic [63:0] result;
  logic [63:0] pcNext;
  logic        pcWrite;
  logic        halt;
  logic        illegal;

  logic [63:0] shadow [32];
  logic [63:0] curPc;
  int          seed;
  int          cycles = 0;

  decodeCore #(.Xlen(64), .NumRegs(32)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("timeout: tests did not finish within %0d cycles", MaxCycles);
      $display("=== FAIL ===");
      $fatal(1, "simulation timed out");
    end
  end

  function automatic rvInst_u rWord(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [6:0] op);
    rvInst_u w;
    w.rFields = {f7, rs2, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic rvInst_u iWord(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] op);
    rvInst_u w;
    w.iFields = {imm, rs1, f3, rd, op};
    return w;
  endfunction

  // offset in bytes with bit 0 dropped by the format
  function automatic rvInst_u bWord(input logic [12:0] off, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3);
    rvInst_u w;
    w.bFields = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    return w;
  endfunction

  function automatic rvInst_u uWord(input logic [19:0] upper, input logic [4:0] rd,
                                    input logic [6:0] op);
    rvInst_u w;
    w.uFields = {upper, rd, op};
    return w;
  endfunction

  function automatic rvInst_u jWord(input logic [20:0] off, input logic [4:0] rd);
    rvInst_u w;
    w.jFields = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    return w;
  endfunction

  function automatic logic [63:0] sext(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one instruction per cycle with wr as the register the model writes
  task automatic execute(input rvInst_u w, input logic [4:0] wr, input logic [63:0] expRes,
                         input logic [63:0] expNext, input logic expPcw,
                         input logic expHalt, input logic expIll);
    @(posedge clk);
    pc <= curPc;
    inst <= w;
    @(negedge clk);
    check("result", result, expRes);
    check("pcNext", pcNext, expNext);
    check("pcWrite", pcWrite, expPcw);
    check("halt", halt, expHalt);
    check("illegal", illegal, expIll);
    if (wr != 5'd0) begin
      shadow[wr] = expRes;
    end
    curPc = curPc + 64'd4;
  endtask

  task automatic alu(input rvInst_u w, input logic [63:0] exp);
    execute(w, w.rFields.rd, exp, curPc + 64'd4, 1'b0, 1'b0, 1'b0);
  endtask

  // add x0, xr, x0 shows the register on result
  task automatic readBack(input logic [4:0] r);
    alu(rWord(7'h00, 5'd0, r, 3'b000, 5'd0, OpReg), shadow[r]);
  endtask

  task automatic verifyRegs();
    for (int r = 0; r < 32; r++) begin
      readBack(5'(r));
    end
  endtask

  task automatic resetTest();
    for (int r = 0; r < 32; r++) begin
      alu(rWord(7'h00, 5'd0, 5'(r), 3'b000, 5'd1, OpReg), 64'd0);
    end
    alu(iWord(12'h05a, 5'd0, 3'b000, 5'd0, OpImm), 64'h5a);
    readBack(5'd0);
  endtask

  task automatic immTest();
    logic [11:0] imm;
    logic [19:0] upper;
    for (int r = 1; r <= 6; r++) begin
      imm = 12'($random(seed));
      alu(iWord(imm, 5'd0, 3'b000, 5'(r), OpImm), {{52{imm[11]}}, imm});
    end
    for (int r = 7; r <= 8; r++) begin
      upper = 20'($random(seed));
      // negative x8 so arithmetic and logical right shifts differ
      if (r == 8) begin
        upper[19] = 1'b1;
      end
      alu(uWord(upper, 5'(r), 7'b0110111), {{32{upper[19]}}, upper, 12'h000});
    end
    alu(rWord(7'h00, 5'd1, 5'd7, 3'b000, 5'd9, OpReg), shadow[7] + shadow[1]);
    alu(rWord(7'h20, 5'd2, 5'd8, 3'b000, 5'd10, OpReg), shadow[8] - shadow[2]);
    alu(rWord(7'h00, 5'd3, 5'd9, 3'b100, 5'd11, OpReg), shadow[9] ^ shadow[3]);
    alu(rWord(7'h00, 5'd4, 5'd10, 3'b110, 5'd12, OpReg), shadow[10] | shadow[4]);
    alu(rWord(7'h00, 5'd12, 5'd11, 3'b111, 5'd13, OpReg), shadow[11] & shadow[12]);
    alu(rWord(7'h00, 5'd8, 5'd7, 3'b010, 5'd14, OpReg),
        {63'd0, $signed(shadow[7]) < $signed(shadow[8])});
    alu(rWord(7'h00, 5'd8, 5'd7, 3'b011, 5'd15, OpReg), {63'd0, shadow[7] < shadow[8]});
    alu(rWord(7'h00, 5'd5, 5'd9, 3'b001, 5'd16, OpReg), shadow[9] << shadow[5][5:0]);
    alu(rWord(7'h00, 5'd6, 5'd10, 3'b101, 5'd17, OpReg), shadow[10] >> shadow[6][5:0]);
    alu(rWord(7'h20, 5'd6, 5'd10, 3'b101, 5'd18, OpReg),
        $signed(shadow[10]) >>> shadow[6][5:0]);
  endtask

  task automatic wordTest();
    logic [11:0] imm;
    logic [4:0]  sh;
    imm = 12'($random(seed));
    sh = 5'($random(seed));
    alu(rWord(7'h00, 5'd7, 5'd9, 3'b000, 5'd19, OpRegW), sext(shadow[9][31:0] + shadow[7][31:0]));
    alu(rWord(7'h20, 5'd9, 5'd8, 3'b000, 5'd20, OpRegW), sext(shadow[8][31:0] - shadow[9][31:0]));
    alu(rWord(7'h00, 5'd5, 5'd9, 3'b001, 5'd26, OpRegW), sext(shadow[9][31:0] << shadow[5][4:0]));
    alu(rWord(7'h00, 5'd6, 5'd8, 3'b101, 5'd27, OpRegW), sext(shadow[8][31:0] >> shadow[6][4:0]));
    alu(rWord(7'h20, 5'd6, 5'd8, 3'b101, 5'd28, OpRegW),
        sext($signed(shadow[8][31:0]) >>> shadow[6][4:0]));
    alu(iWord(imm, 5'd9, 3'b000, 5'd29, OpImmW), sext(shadow[9][31:0] + {{20{imm[11]}}, imm}));
    alu(iWord({7'h00, sh}, 5'd10, 3'b001, 5'd30, OpImmW), sext(shadow[10][31:0] << sh));
    alu(iWord({7'h00, sh}, 5'd8, 3'b101, 5'd31, OpImmW), sext(shadow[8][31:0] >> sh));
    alu(iWord({7'h20, sh}, 5'd8, 3'b101, 5'd31, OpImmW), sext($signed(shadow[8][31:0]) >>> sh));
  endtask

  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                        input logic taken);
    logic [12:0] off;
    logic [63:0] target;
    off = 13'($random(seed)) & 13'h1ffe;
    target = taken ? curPc + {{51{off[12]}}, off} : curPc + 64'd4;
    execute(bWord(off, rs2, rs1, f3), 5'd0, 64'd0, target, taken, 1'b0, 1'b0);
  endtask

  task automatic branchTest();
    // x21 = -5 and x22 = 7
    alu(iWord(12'hffb, 5'd0, 3'b000, 5'd21, OpImm), 64'hffff_ffff_ffff_fffb);
    alu(iWord(12'h007, 5'd0, 3'b000, 5'd22, OpImm), 64'd7);
    branch(3'b000, 5'd22, 5'd22, shadow[22] == shadow[22]);
    branch(3'b000, 5'd21, 5'd22, shadow[21] == shadow[22]);
    branch(3'b001, 5'd21, 5'd22, shadow[21] != shadow[22]);
    branch(3'b001, 5'd22, 5'd22, shadow[22] != shadow[22]);
    branch(3'b100, 5'd21, 5'd22, $signed(shadow[21]) < $signed(shadow[22]));
    branch(3'b100, 5'd22, 5'd21, $signed(shadow[22]) < $signed(shadow[21]));
    branch(3'b101, 5'd22, 5'd21, $signed(shadow[22]) >= $signed(shadow[21]));
    branch(3'b101, 5'd21, 5'd22, $signed(shadow[21]) >= $signed(shadow[22]));
    branch(3'b110, 5'd22, 5'd21, shadow[22] < shadow[21]);
    branch(3'b110, 5'd21, 5'd22, shadow[21] < shadow[22]);
    branch(3'b111, 5'd21, 5'd22, shadow[21] >= shadow[22]);
    branch(3'b111, 5'd22, 5'd21, shadow[22] >= shadow[21]);
  endtask

  task automatic jumpTest();
    logic [20:0] jOff;
    logic [11:0] imm;
    logic [19:0] upper;
    logic [63:0] target;
    jOff = 21'($random(seed)) & 21'h1ffffe;
    execute(jWord(jOff, 5'd23), 5'd23, curPc + 64'd4, curPc + {{43{jOff[20]}}, jOff},
            1'b1, 1'b0, 1'b0);
    // odd x22 plus an even imm gives an odd sum
    imm = 12'($random(seed)) & 12'hffe;
    target = (shadow[22] + {{52{imm[11]}}, imm}) & ~64'd1;
    execute(iWord(imm, 5'd22, 3'b000, 5'd24, 7'b1100111), 5'd24, curPc + 64'd4, target,
            1'b1, 1'b0, 1'b0);
    upper = 20'($random(seed));
    alu(uWord(upper, 5'd25, 7'b0010111), curPc + sext({upper, 12'h000}));
    readBack(5'd23);
    readBack(5'd24);
  endtask

  task automatic haltTest();
    execute(iWord(12'h001, 5'd0, 3'b000, 5'd0, 7'b1110011), 5'd0, 64'd0, curPc + 64'd4,
            1'b0, 1'b1, 1'b0);
    // ld, sd, mul and an all-zero word
    execute(iWord(12'h010, 5'd2, 3'b011, 5'd1, 7'b0000011), 5'd0, 64'd0, curPc + 64'd4,
            1'b0, 1'b0, 1'b1);
    execute(rWord(7'h00, 5'd3, 5'd2, 3'b011, 5'd8, 7'b0100011), 5'd0, 64'd0, curPc + 64'd4,
            1'b0, 1'b0, 1'b1);
    execute(rWord(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, OpReg), 5'd0, 64'd0, curPc + 64'd4,
            1'b0, 1'b0, 1'b1);
    execute('0, 5'd0, 64'd0, curPc + 64'd4, 1'b0, 1'b0, 1'b1);
    verifyRegs();
  endtask

  initial begin
    seed = 32'hf59b_4b34;
    curPc = 64'h0000_0000_8000_0000;
    arstN = 1'b0;
    pc = '0;
    inst = '0;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
    resetTest();
    immTest();
    wordTest();
    branchTest();
    jumpTest();
    haltTest();
    @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== verilog/decodeCore.sv ====
module decodeCore #(
  parameter int Xlen    = rvPkg::XlenDefault,
  parameter int NumRegs = 32
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic [Xlen-1:0] pc,
  input  logic [31:0]     inst,
  output logic [Xlen-1:0] result,
  output logic [Xlen-1:0] pcNext,
  output logic            pcWrite,
  output logic            halt,
  output logic            illegal
);
  import rvPkg::*;

  decoded_t        dec;
  logic [Xlen-1:0] rdata1;
  logic [Xlen-1:0] rdata2;
  logic [Xlen-1:0] src1;
  logic [Xlen-1:0] src2;
  logic [Xlen-1:0] branchOffset;
  logic [Xlen-1:0] exResult;
  logic            exPcWrite;
  logic            regWen;

  instDecoder #(.NumRegs(NumRegs)) uDecoder (
    .inst(inst),
    .dec (dec)
  );

  regFile #(.Xlen(Xlen), .NumRegs(NumRegs)) uRegFile (
    .clk   (clk),
    .arstN (arstN),
    .rs1   (dec.rs1),
    .rs2   (dec.rs2),
    .rd    (dec.rd),
    .wen   (regWen),
    .wdata (exResult),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

  operandSelect #(.Xlen(Xlen)) uOperandSelect (
    .dec         (dec),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .src1        (src1),
    .src2        (src2),
    .branchOffset(branchOffset)
  );

  execUnit #(.Xlen(Xlen)) uExecUnit (
    .func        (dec.func),
    .pc          (pc),
    .src1        (src1),
    .src2        (src2),
    .branchOffset(branchOffset),
    .result      (exResult),
    .pcNext      (pcNext),
    .pcWrite     (exPcWrite)
  );

  assign halt = dec.func == FuncEbreak;
  assign illegal = dec.func == FuncIllegal;
  assign regWen = dec.regWrite & ~(halt | illegal);

  // shows zero when nothing gets written
  assign result = regWen ? exResult : '0;
  assign pcWrite = dec.pcWrite & exPcWrite;

endmodule

// ==== verilog/execUnit.sv ====
module execUnit #(
  parameter int Xlen = 64
) (
  input  rvPkg::rvFunc_e  func,
  input  logic [Xlen-1:0] pc,
  input  logic [Xlen-1:0] src1,
  input  logic [Xlen-1:0] src2,
  input  logic [Xlen-1:0] branchOffset,
  output logic [Xlen-1:0] result,
  output logic [Xlen-1:0] pcNext,
  output logic            pcWrite
);
  import rvPkg::*;

  localparam int ShamtW = $clog2(Xlen);

  logic [ShamtW-1:0] shamt;
  logic [4:0]        shamtWord;
  logic [31:0]       word;
  logic [Xlen-1:0]   sum;
  logic [Xlen-1:0]   pcPlus4;
  logic              taken;

  function automatic logic [Xlen-1:0] sext32(input logic [31:0] w);
    return {{(Xlen - 32){w[31]}}, w};
  endfunction

  assign shamt = src2[ShamtW-1:0];
  assign shamtWord = src2[4:0];
  assign sum = src1 + src2;
  assign pcPlus4 = pc + Xlen'(4);

  // 32-bit ops of the W forms
  always_comb begin
    case (func)
      FuncAddw, FuncAddiw: word = src1[31:0] + src2[31:0];
      FuncSubw:            word = src1[31:0] - src2[31:0];
      FuncSllw, FuncSlliw: word = src1[31:0] << shamtWord;
      FuncSrlw, FuncSrliw: word = src1[31:0] >> shamtWord;
      FuncSraw, FuncSraiw: word = $signed(src1[31:0]) >>> shamtWord;
      default:             word = '0;
    endcase
  end

  always_comb begin
    case (func)
      FuncAdd, FuncAddi:   result = sum;
      FuncSub:             result = src1 - src2;
      FuncSll, FuncSlli:   result = src1 << shamt;
      FuncSlt, FuncSlti:   result = Xlen'($signed(src1) < $signed(src2));
      FuncSltu, FuncSltiu: result = Xlen'(src1 < src2);
      FuncXor, FuncXori:   result = src1 ^ src2;
      FuncSrl, FuncSrli:   result = src1 >> shamt;
      FuncSra, FuncSrai:   result = $signed(src1) >>> shamt;
      FuncOr, FuncOri:     result = src1 | src2;
      FuncAnd, FuncAndi:   result = src1 & src2;
      FuncAddw, FuncAddiw, FuncSubw, FuncSllw, FuncSlliw,
      FuncSrlw, FuncSrliw, FuncSraw, FuncSraiw: begin
        result = sext32(word);
      end
      FuncLui:             result = src1;
      FuncAuipc:           result = pc + src1;
      // link value
      FuncJal, FuncJalr:   result = pcPlus4;
      default:             result = '0;
    endcase
  end

  always_comb begin
    case (func)
      FuncBeq:  taken = src1 == src2;
      FuncBne:  taken = src1 != src2;
      FuncBlt:  taken = $signed(src1) < $signed(src2);
      FuncBge:  taken = $signed(src1) >= $signed(src2);
      FuncBltu: taken = src1 < src2;
      FuncBgeu: taken = src1 >= src2;
      default:  taken = 1'b0;
    endcase
  end

  always_comb begin
    pcNext = pcPlus4;
    pcWrite = 1'b0;
    if (taken || func == FuncJal) begin
      pcNext = pc + branchOffset;
      pcWrite = 1'b1;
    end else if (func == FuncJalr) begin
      // target lsb forced low
      pcNext = {sum[Xlen-1:1], 1'b0};
      pcWrite = 1'b1;
    end
  end

endmodule

// ==== verilog/instDecoder.sv ====
module instDecoder #(
  parameter int NumRegs = 32
) (
  input  rvPkg::rvInst_u  inst,
  output rvPkg::decoded_t dec
);
  import rvPkg::*;

  typedef struct packed {
    rvFunc_e   func;
    rvFormat_e fmt;
    logic      regWrite;
    logic      pcWrite;
  } match_t;

  logic [31:0] word;
  match_t      hit;
  logic [31:0] imm;
  logic        usesRd;
  logic        usesRs1;
  logic        usesRs2;
  logic        badReg;

  assign word = inst;

  // first matching pattern wins
  always_comb begin
    hit = '{FuncIllegal, FmtSpecial, 1'b0, 1'b0};
    casez (word)
      // register ops
      32'b0000000_?????_?????_000_?????_0110011: hit = '{FuncAdd,   FmtR, 1'b1, 1'b0};
      32'b0100000_?????_?????_000_?????_0110011: hit = '{FuncSub,   FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_001_?????_0110011: hit = '{FuncSll,   FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_010_?????_0110011: hit = '{FuncSlt,   FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_011_?????_0110011: hit = '{FuncSltu,  FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_100_?????_0110011: hit = '{FuncXor,   FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_101_?????_0110011: hit = '{FuncSrl,   FmtR, 1'b1, 1'b0};
      32'b0100000_?????_?????_101_?????_0110011: hit = '{FuncSra,   FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_110_?????_0110011: hit = '{FuncOr,    FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_111_?????_0110011: hit = '{FuncAnd,   FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_000_?????_0111011: hit = '{FuncAddw,  FmtR, 1'b1, 1'b0};
      32'b0100000_?????_?????_000_?????_0111011: hit = '{FuncSubw,  FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_001_?????_0111011: hit = '{FuncSllw,  FmtR, 1'b1, 1'b0};
      32'b0000000_?????_?????_101_?????_0111011: hit = '{FuncSrlw,  FmtR, 1'b1, 1'b0};
      32'b0100000_?????_?????_101_?????_0111011: hit = '{FuncSraw,  FmtR, 1'b1, 1'b0};
      // immediate ops with a 6-bit shamt on rv64 shifts
      32'b???????_?????_?????_000_?????_0010011: hit = '{FuncAddi,  FmtI, 1'b1, 1'b0};
      32'b???????_?????_?????_010_?????_0010011: hit = '{FuncSlti,  FmtI, 1'b1, 1'b0};
      32'b???????_?????_?????_011_?????_0010011: hit = '{FuncSltiu, FmtI, 1'b1, 1'b0};
      32'b???????_?????_?????_100_?????_0010011: hit = '{FuncXori,  FmtI, 1'b1, 1'b0};
      32'b???????_?????_?????_110_?????_0010011: hit = '{FuncOri,   FmtI, 1'b1, 1'b0};
      32'b???????_?????_?????_111_?????_0010011: hit = '{FuncAndi,  FmtI, 1'b1, 1'b0};
      32'b000000?_?????_?????_001_?????_0010011: hit = '{FuncSlli,  FmtI, 1'b1, 1'b0};
      32'b000000?_?????_?????_101_?????_0010011: hit = '{FuncSrli,  FmtI, 1'b1, 1'b0};
      32'b010000?_?????_?????_101_?????_0010011: hit = '{FuncSrai,  FmtI, 1'b1, 1'b0};
      32'b???????_?????_?????_000_?????_0011011: hit = '{FuncAddiw, FmtI, 1'b1, 1'b0};
      32'b0000000_?????_?????_001_?????_0011011: hit = '{FuncSlliw, FmtI, 1'b1, 1'b0};
      32'b0000000_?????_?????_101_?????_0011011: hit = '{FuncSrliw, FmtI, 1'b1, 1'b0};
      32'b0100000_?????_?????_101_?????_0011011: hit = '{FuncSraiw, FmtI, 1'b1, 1'b0};
      32'b???????_?????_?????_000_?????_1100111: hit = '{FuncJalr,  FmtI, 1'b1, 1'b1};
      // branches
      32'b???????_?????_?????_000_?????_1100011: hit = '{FuncBeq,   FmtB, 1'b0, 1'b1};
      32'b???????_?????_?????_001_?????_1100011: hit = '{FuncBne,   FmtB, 1'b0, 1'b1};
      32'b???????_?????_?????_100_?????_1100011: hit = '{FuncBlt,   FmtB, 1'b0, 1'b1};
      32'b???????_?????_?????_101_?????_1100011: hit = '{FuncBge,   FmtB, 1'b0, 1'b1};
      32'b???????_?????_?????_110_?????_1100011: hit = '{FuncBltu,  FmtB, 1'b0, 1'b1};
      32'b???????_?????_?????_111_?????_1100011: hit = '{FuncBgeu,  FmtB, 1'b0, 1'b1};
      32'b???????_?????_?????_???_?????_0110111: hit = '{FuncLui,   FmtU, 1'b1, 1'b0};
      32'b???????_?????_?????_???_?????_0010111: hit = '{FuncAuipc, FmtU, 1'b1, 1'b0};
      32'b???????_?????_?????_???_?????_1101111: hit = '{FuncJal,   FmtJ, 1'b1, 1'b1};
      32'b0000000_00001_00000_000_00000_1110011: hit = '{FuncEbreak, FmtSpecial, 1'b0, 1'b0};
      default: hit = '{FuncIllegal, FmtSpecial, 1'b0, 1'b0};
    endcase
  end

  // immediate and register fields by format
  always_comb begin
    imm = '0;
    usesRd = 1'b0;
    usesRs1 = 1'b0;
    usesRs2 = 1'b0;
    case (hit.fmt)
      FmtR: begin
        usesRd = 1'b1;
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
      end
      FmtI: begin
        imm = {{20{inst.iFields.imm11to0[11]}}, inst.iFields.imm11to0};
        usesRd = 1'b1;
        usesRs1 = 1'b1;
      end
      FmtB: begin
        imm = {{19{inst.bFields.imm12}}, inst.bFields.imm12, inst.bFields.imm11,
               inst.bFields.imm10to5, inst.bFields.imm4to1, 1'b0};
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
      end
      FmtU: begin
        imm = {inst.uFields.imm31to12, 12'b0};
        usesRd = 1'b1;
      end
      FmtJ: begin
        imm = {{11{inst.jFields.imm20}}, inst.jFields.imm20, inst.jFields.imm19to12,
               inst.jFields.imm11, inst.jFields.imm10to1, 1'b0};
        usesRd = 1'b1;
      end
      default: imm = '0;
    endcase
  end

  // registers at or above NumRegs (x16 and up on rv64e)
  assign badReg = (usesRd && inst.rFields.rd >= NumRegs)
               || (usesRs1 && inst.rFields.rs1 >= NumRegs)
               || (usesRs2 && inst.rFields.rs2 >= NumRegs);

  always_comb begin
    dec = '0;
    if (hit.func == FuncIllegal || badReg) begin
      dec.func = FuncIllegal;
      dec.fmt = FmtSpecial;
      dec.illegal = 1'b1;
    end else begin
      dec.func = hit.func;
      dec.fmt = hit.fmt;
      dec.rd = usesRd ? inst.rFields.rd : 5'd0;
      dec.rs1 = usesRs1 ? inst.rFields.rs1 : 5'd0;
      dec.rs2 = usesRs2 ? inst.rFields.rs2 : 5'd0;
      dec.imm = imm;
      dec.regWrite = hit.regWrite;
      dec.pcWrite = hit.pcWrite;
    end
  end

endmodule

// ==== verilog/operandSelect.sv ====
module operandSelect #(
  parameter int Xlen = 64
) (
  input  rvPkg::decoded_t dec,
  input  logic [Xlen-1:0] rdata1,
  input  logic [Xlen-1:0] rdata2,
  output logic [Xlen-1:0] src1,
  output logic [Xlen-1:0] src2,
  output logic [Xlen-1:0] branchOffset
);
  import rvPkg::*;

  logic [Xlen-1:0] immX;

  assign immX = {{(Xlen - 32){dec.imm[31]}}, dec.imm};

  always_comb begin
    src1 = '0;
    src2 = '0;
    branchOffset = '0;
    case (dec.fmt)
      FmtR: begin
        src1 = rdata1;
        src2 = rdata2;
      end
      FmtI: begin
        src1 = rdata1;
        src2 = immX;
      end
      FmtB: begin
        src1 = rdata1;
        src2 = rdata2;
        branchOffset = immX;
      end
      // upper immediate already sits in bits 31:12
      FmtU: begin
        src1 = immX;
      end
      FmtJ: begin
        branchOffset = immX;
      end
      default: begin
        src1 = '0;
        src2 = '0;
        branchOffset = '0;
      end
    endcase
  end

endmodule

// ==== verilog/regFile.sv ====
module regFile #(
  parameter int Xlen    = 64,
  parameter int NumRegs = 32
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            wen,
  input  logic [Xlen-1:0] wdata,
  output logic [Xlen-1:0] rdata1,
  output logic [Xlen-1:0] rdata2
);

  logic [Xlen-1:0] regs [NumRegs];

  // x0 is never written
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0 && rd < NumRegs) begin
      regs[rd] <= wdata;
    end
  end

  // reads out of range return zero as well
  assign rdata1 = (rs1 == 5'd0 || rs1 >= NumRegs) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0 || rs2 >= NumRegs) ? '0 : regs[rs2];

endmodule

// ==== verilog/rvPkg.sv ====
package rvPkg;

  localparam int XlenDefault = 64;

  // one code per kept instruction
  typedef enum logic [5:0] {
    FuncIllegal,
    FuncAdd,
    FuncSub,
    FuncSll,
    FuncSlt,
    FuncSltu,
    FuncXor,
    FuncSrl,
    FuncSra,
    FuncOr,
    FuncAnd,
    FuncAddi,
    FuncSlti,
    FuncSltiu,
    FuncXori,
    FuncOri,
    FuncAndi,
    FuncSlli,
    FuncSrli,
    FuncSrai,
    FuncAddw,
    FuncSubw,
    FuncSllw,
    FuncSrlw,
    FuncSraw,
    FuncAddiw,
    FuncSlliw,
    FuncSrliw,
    FuncSraiw,
    FuncLui,
    FuncAuipc,
    FuncJal,
    FuncJalr,
    FuncBeq,
    FuncBne,
    FuncBlt,
    FuncBge,
    FuncBltu,
    FuncBgeu,
    FuncEbreak
  } rvFunc_e;

  typedef enum logic [2:0] {
    FmtR,
    FmtI,
    FmtS,
    FmtB,
    FmtU,
    FmtJ,
    FmtSpecial
  } rvFormat_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rType_t;

  typedef struct packed {
    logic [11:0] imm11to0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iType_t;

  typedef struct packed {
    logic [6:0] imm11to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4to0;
    logic [6:0] opcode;
  } sType_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bType_t;

  typedef struct packed {
    logic [19:0] imm31to12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uType_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jType_t;

  // same 32 bits, six field layouts
  typedef union packed {
    rType_t rFields;
    iType_t iFields;
    sType_t sFields;
    bType_t bFields;
    uType_t uFields;
    jType_t jFields;
  } rvInst_u;

  typedef struct packed {
    rvFunc_e     func;
    rvFormat_e   fmt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    // already scaled, e.g. branch offsets in bytes
    logic [31:0] imm;
    logic        regWrite;
    logic        pcWrite;
    logic        illegal;
  } decoded_t;

endpackage
